//--- common/st_glue_pkg.sv
`default_nettype none

package st_glue_pkg;

	// clock rates
	localparam logic [31:0] SYSTEM_CLOCK_HZ = 32'd32084988; // nominal clk_32
	localparam logic [31:0] MFP_CLOCK_HZ = 32'd2457600;     // mfp timer clock target

	// reset sequencer
	localparam logic [6:0] RESET_CYCLES = 7'd127;           // counter load value
	localparam logic [6:0] MCU_RESET_ASSERT_AT = 7'd10;     // mcu reset goes low here
	localparam logic [6:0] MCU_RESET_RELEASE_BELOW = 7'd8;  // and is let go below this

	// timebase
	localparam logic [4:0] EN_2M_DIV = 5'd16;               // clk_32 cycles per 2 MHz pulse
	localparam logic [3:0] SND_IRQ_DELAY_LEN = 4'd8;        // taps, like the 74LS164

	// audio centring
	localparam logic [9:0] YM_MIDPOINT = 10'd512;
	localparam logic [7:0] DMA_MIDPOINT = 8'd128;

	// rtc
	localparam logic [3:0] RTC_YEAR_BIAS = 4'd2;            // gemdos counts years from 1980
	localparam logic [3:0] RTC_BANK_REG = 4'd13;            // bank/mode register

	// bcd time from the io controller, one nibble per digit
	typedef struct packed {
		logic [3:0] sec_lo;
		logic [3:0] sec_hi;
		logic [3:0] min_lo;
		logic [3:0] min_hi;
		logic [3:0] hour_lo;
		logic [3:0] hour_hi;
		logic [3:0] day_lo;
		logic [3:0] day_hi;
		logic [3:0] mon_lo;
		logic [3:0] mon_hi;
		logic [3:0] year_lo;
		logic [3:0] year_hi;
		logic [3:0] dow;      // day of week
	} rtc_time_t;

	// cpu side access to the rp5c15
	typedef struct packed {
		logic       cs;       // chip select, active high
		logic       wr;       // write strobe, active high
		logic [3:0] addr;     // register number
		logic [3:0] wdata;    // write nibble
	} rtc_bus_t;

	// raw samples, all offset binary
	typedef struct packed {
		logic [9:0] ym;       // psg sum
		logic [7:0] dma_l;    // ste dma sound left
		logic [7:0] dma_r;    // ste dma sound right
	} audio_in_t;

	// mixed samples for the sigma-delta dac
	typedef struct packed {
		logic signed [14:0] left;
		logic signed [14:0] right;
	} audio_out_t;

endpackage

`default_nettype wire

//--- hdl/st_reset_seq.sv
`timescale 1ns/10ps
`default_nettype none

module st_reset_seq (
	input  logic clk_32,
	input  logic xsint,              // power-on reset, active low
	input  logic sys_reset_n_i,      // external reset button
	input  logic cpu_reset_n_i,      // reset instruction from the cpu
	output logic reset_o,            // system reset
	output logic peripheral_reset_o, // system reset or cpu reset
	output logic mcu_reset_n_o       // memory controller reset
);

	logic [6:0] reset_cnt;           // counts down to zero after release
	logic       cpu_reset_n_d;       // previous cpu_reset_n_i for edge detect
	logic       cpu_reset_fall;

	assign cpu_reset_fall = cpu_reset_n_d & ~cpu_reset_n_i;

	// main reset counter
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			reset_cnt <= st_glue_pkg::RESET_CYCLES;
		end else if (!sys_reset_n_i) begin
			reset_cnt <= st_glue_pkg::RESET_CYCLES; // held while button is down
		end else if (reset_cnt != 7'd0) begin
			reset_cnt <= reset_cnt - 7'd1;
		end
	end

	// registered reset outputs
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			reset_o <= 1'b1;
			peripheral_reset_o <= 1'b1;
			cpu_reset_n_d <= 1'b1;
		end else begin
			reset_o <= reset_cnt != 7'd0;
			peripheral_reset_o <= reset_o | ~cpu_reset_n_i; // one cycle behind reset_o
			cpu_reset_n_d <= cpu_reset_n_i;
		end
	end

	// the memory controller only sees a short window near the end of the count,
	// its refresh must keep running while the rest of the system is held
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mcu_reset_n_o <= 1'b1;
		end else if (cpu_reset_fall) begin
			mcu_reset_n_o <= 1'b0;     // cpu reset instruction
		end else if (reset_cnt == st_glue_pkg::MCU_RESET_ASSERT_AT) begin
			mcu_reset_n_o <= 1'b0;
		end else if (reset_cnt < st_glue_pkg::MCU_RESET_RELEASE_BELOW) begin
			mcu_reset_n_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/st_mfp_timebase.sv
`timescale 1ns/10ps
`default_nettype none

module st_mfp_timebase (
	input  logic clk_32,
	input  logic xsint,
	input  logic snd_irq_i,      // dma sound interrupt, high while active
	input  logic ste_i,          // ste mode
	input  logic mono_detect_i,  // low for monochrome monitor
	output logic mfp_clk_o,      // about 2.4576 MHz
	output logic en_2m_o,        // one clk_32 pulse per 2 MHz period
	output logic timer_a_o,      // delayed sound interrupt to timer a
	output logic mfp_io7_o       // mfp gpio bit 7
);

	logic [31:0] mfp_acc;        // fractional phase accumulator
	logic [3:0]  div_cnt;        // 2 MHz divider
	logic [st_glue_pkg::SND_IRQ_DELAY_LEN-1:0] snd_dly; // shift register taps
	logic        snd_dly_clr_n;

	// fractional divider, toggles twice per mfp clock period
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mfp_acc <= 32'd0;
			mfp_clk_o <= 1'b0;
		end else if (mfp_acc < st_glue_pkg::SYSTEM_CLOCK_HZ / 2) begin
			mfp_acc <= mfp_acc + st_glue_pkg::MFP_CLOCK_HZ;
		end else begin
			// overflow, carry the remainder into the next period
			mfp_acc <= mfp_acc - (st_glue_pkg::SYSTEM_CLOCK_HZ / 2 - st_glue_pkg::MFP_CLOCK_HZ);
			mfp_clk_o <= ~mfp_clk_o;
		end
	end

	// 2 MHz enable, free running
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			div_cnt <= 4'd0;
			en_2m_o <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 4'd1;  // wraps every 16
			en_2m_o <= {1'b0, div_cnt} == st_glue_pkg::EN_2M_DIV - 5'd1;
		end
	end

	// ste delays the sound interrupt by 1/250000 s before timer a
	assign snd_dly_clr_n = xsint & snd_irq_i; // low irq clears the chain at once

	always_ff @(posedge clk_32 or negedge snd_dly_clr_n) begin
		if (!snd_dly_clr_n) begin
			snd_dly <= '0;
		end else if (en_2m_o) begin
			snd_dly <= {snd_dly[st_glue_pkg::SND_IRQ_DELAY_LEN-2:0], 1'b1};
		end
	end

	assign timer_a_o = snd_dly[st_glue_pkg::SND_IRQ_DELAY_LEN-1]; // last tap

	// mono detect shares io7 with the sound interrupt on the ste
	assign mfp_io7_o = mono_detect_i ^ (ste_i & snd_irq_i);

endmodule

`default_nettype wire

//--- rtc/st_rtc.sv
`timescale 1ns/10ps
`default_nettype none

module st_rtc (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  logic                   periph_reset_i, // clears the bank select
	input  st_glue_pkg::rtc_bus_t  rtc_bus_i,
	input  st_glue_pkg::rtc_time_t rtc_time_i,     // current time from io controller
	output logic [3:0]             rtc_rdata_o
);

	logic       bank;            // 0 time registers, 1 alarm/scratch
	logic [3:0] bank1_mem [16];  // bank 1 nibbles
	logic       wr_en;
	logic [3:0] time_nib;        // bank 0 digit for the current address

	assign wr_en = rtc_bus_i.cs & rtc_bus_i.wr;

	// bank register
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			bank <= 1'b0;
		end else if (periph_reset_i) begin
			bank <= 1'b0;
		end else if (wr_en && rtc_bus_i.addr == st_glue_pkg::RTC_BANK_REG) begin
			bank <= rtc_bus_i.wdata[0];  // only the bank bit is kept
		end
	end

	// bank 1 store, every address except the mode register
	always_ff @(posedge clk_32) begin
		if (wr_en && rtc_bus_i.addr != st_glue_pkg::RTC_BANK_REG) begin
			bank1_mem[rtc_bus_i.addr] <= rtc_bus_i.wdata;
		end
	end

	// time digits in rp5c15 register order
	always_comb begin
		case (rtc_bus_i.addr)
			4'd0:    time_nib = rtc_time_i.sec_lo;
			4'd1:    time_nib = rtc_time_i.sec_hi;
			4'd2:    time_nib = rtc_time_i.min_lo;
			4'd3:    time_nib = rtc_time_i.min_hi;
			4'd4:    time_nib = rtc_time_i.hour_lo;
			4'd5:    time_nib = rtc_time_i.hour_hi;
			4'd6:    time_nib = rtc_time_i.dow;       // day of week sits before the date
			4'd7:    time_nib = rtc_time_i.day_lo;
			4'd8:    time_nib = rtc_time_i.day_hi;
			4'd9:    time_nib = rtc_time_i.mon_lo;
			4'd10:   time_nib = rtc_time_i.mon_hi;
			4'd11:   time_nib = rtc_time_i.year_lo + st_glue_pkg::RTC_YEAR_BIAS;
			4'd12:   time_nib = rtc_time_i.year_hi;
			default: time_nib = 4'hf;
		endcase
	end

	// read mux, no latency
	always_comb begin
		if (rtc_bus_i.addr == st_glue_pkg::RTC_BANK_REG) begin
			rtc_rdata_o = {1'b1, 2'b00, bank};  // timer enable set, bank bit
		end else if (rtc_bus_i.addr == 4'd14) begin
			rtc_rdata_o = 4'h0;                 // test register
		end else if (rtc_bus_i.addr == 4'd15) begin
			rtc_rdata_o = 4'hc;                 // reset register
		end else if (bank) begin
			rtc_rdata_o = bank1_mem[rtc_bus_i.addr];
		end else begin
			rtc_rdata_o = time_nib;
		end

		// no time from the io controller yet, so the chip looks absent
		if (rtc_time_i == '0) begin
			rtc_rdata_o = 4'hf;
		end
	end

endmodule

`default_nettype wire

//--- audio/st_audio_mix.sv
`timescale 1ns/10ps
`default_nettype none

module st_audio_mix (
	input  logic                    clk_32,
	input  logic                    xsint,
	input  st_glue_pkg::audio_in_t  audio_i,  // new sample every cycle
	output st_glue_pkg::audio_out_t audio_o   // three cycles behind audio_i
);

	// stage 1, centred two's complement samples
	logic [9:0] ym_c;
	logic [7:0] dma_l_c;
	logic [7:0] dma_r_c;

	// stage 2, each term widened to 15 bits
	logic signed [14:0] ym_x;
	logic signed [14:0] dma_l_x;
	logic signed [14:0] dma_r_x;

	// stage 1, remove the dc offset
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ym_c <= 10'd0;
			dma_l_c <= 8'd0;
			dma_r_c <= 8'd0;
		end else begin
			ym_c <= audio_i.ym - st_glue_pkg::YM_MIDPOINT;
			dma_l_c <= audio_i.dma_l - st_glue_pkg::DMA_MIDPOINT;
			dma_r_c <= audio_i.dma_r - st_glue_pkg::DMA_MIDPOINT;
		end
	end

	// stage 2, expand to 14 bits plus one guard bit
	// the low bits repeat the top of the sample, so full scale stays full scale
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ym_x <= 15'sd0;
			dma_l_x <= 15'sd0;
			dma_r_x <= 15'sd0;
		end else begin
			ym_x <= {ym_c[9], ym_c, ym_c[9:6]};            // 1 + 10 + 4
			dma_l_x <= {dma_l_c[7], dma_l_c, dma_l_c[7:2]}; // 1 + 8 + 6
			dma_r_x <= {dma_r_c[7], dma_r_c, dma_r_c[7:2]};
		end
	end

	// stage 3, psg is mono so it goes into both channels
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			audio_o <= '0;
		end else begin
			audio_o.left <= ym_x + dma_l_x;
			audio_o.right <= ym_x + dma_r_x;
		end
	end

endmodule

`default_nettype wire

//--- hdl/st_glue_top.sv
`timescale 1ns/10ps
`default_nettype none

module st_glue_top (
	input  logic                    clk_32,
	input  logic                    xsint,
	input  logic                    sys_reset_n_i,
	input  logic                    cpu_reset_n_i,
	input  logic                    ste_i,
	input  logic                    mono_detect_i,
	input  logic                    snd_irq_i,
	input  st_glue_pkg::rtc_bus_t   rtc_bus_i,
	input  st_glue_pkg::rtc_time_t  rtc_time_i,
	input  st_glue_pkg::audio_in_t  audio_i,
	output logic                    reset_o,
	output logic                    peripheral_reset_o,
	output logic                    mcu_reset_n_o,
	output logic                    mfp_clk_o,
	output logic                    en_2m_o,
	output logic                    timer_a_o,
	output logic                    mfp_io7_o,
	output logic [3:0]              rtc_rdata_o,
	output st_glue_pkg::audio_out_t audio_o
);

	st_reset_seq st_reset_seq_i (
		.clk_32             (clk_32),
		.xsint              (xsint),
		.sys_reset_n_i      (sys_reset_n_i),
		.cpu_reset_n_i      (cpu_reset_n_i),
		.reset_o            (reset_o),
		.peripheral_reset_o (peripheral_reset_o),
		.mcu_reset_n_o      (mcu_reset_n_o)
	);

	st_mfp_timebase st_mfp_timebase_i (
		.clk_32        (clk_32),
		.xsint         (xsint),
		.snd_irq_i     (snd_irq_i),
		.ste_i         (ste_i),
		.mono_detect_i (mono_detect_i),
		.mfp_clk_o     (mfp_clk_o),
		.en_2m_o       (en_2m_o),
		.timer_a_o     (timer_a_o),
		.mfp_io7_o     (mfp_io7_o)
	);

	st_rtc st_rtc_i (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.periph_reset_i (peripheral_reset_o), // bank drops on any peripheral reset
		.rtc_bus_i      (rtc_bus_i),
		.rtc_time_i     (rtc_time_i),
		.rtc_rdata_o    (rtc_rdata_o)
	);

	st_audio_mix st_audio_mix_i (
		.clk_32  (clk_32),
		.xsint   (xsint),
		.audio_i (audio_i),
		.audio_o (audio_o)
	);

endmodule

`default_nettype wire

//--- dv/st_glue_assert.sv
`timescale 1ns/10ps
`default_nettype none

module st_glue_assert (
	input logic                    clk_32,
	input logic                    xsint,
	input logic                    sys_reset_n_i,
	input logic                    reset_o,
	input logic                    mcu_reset_n_o,
	input logic                    en_2m_o,
	input st_glue_pkg::audio_in_t  audio_i,
	input st_glue_pkg::audio_out_t audio_o
);

	logic [6:0] shadow_cnt; // reset counter as it should run
	logic [7:0] rise_cnt;   // cycles since sys_reset_n_i went high
	logic [4:0] en_gap;     // cycles since the last en_2m pulse

	// offset binary sample to its 15 bit term
	function automatic int mix_term(input int raw, input int bits, input int tail);
		int c;
		c = raw - (1 << (bits - 1));
		return c * (1 << tail) + ((c & ((1 << bits) - 1)) >> (bits - tail));
	endfunction

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			shadow_cnt <= st_glue_pkg::RESET_CYCLES;
			rise_cnt <= 8'd0;
			en_gap <= 5'd0;
		end else begin
			if (!sys_reset_n_i) begin
				shadow_cnt <= st_glue_pkg::RESET_CYCLES;
			end else if (shadow_cnt != 7'd0) begin
				shadow_cnt <= shadow_cnt - 7'd1;
			end
			if (!sys_reset_n_i) begin
				rise_cnt <= 8'd0;
			end else if (rise_cnt != 8'hff) begin
				rise_cnt <= rise_cnt + 8'd1; // saturates
			end
			if (en_2m_o) begin
				en_gap <= 5'd1;
			end else if (en_gap != 5'd0 && en_gap != 5'd31) begin
				en_gap <= en_gap + 5'd1;
			end
		end
	end

	a_en_2m_spacing: assert property (@(posedge clk_32) disable iff (!xsint)
		en_2m_o && en_gap != 5'd0 |-> en_gap == st_glue_pkg::EN_2M_DIV)
		else $error("en_2m_o pulse came early");
	a_en_2m_missing: assert property (@(posedge clk_32) disable iff (!xsint)
		en_gap == st_glue_pkg::EN_2M_DIV |-> en_2m_o)
		else $error("en_2m_o pulse missing");

	// reset_o held for 128 cycles, then low
	a_reset_held: assert property (@(posedge clk_32) disable iff (!xsint)
		sys_reset_n_i && rise_cnt <= {1'b0, st_glue_pkg::RESET_CYCLES} |-> reset_o)
		else $error("reset_o fell too early");
	a_reset_release: assert property (@(posedge clk_32) disable iff (!xsint)
		sys_reset_n_i && rise_cnt > {1'b0, st_glue_pkg::RESET_CYCLES} |-> !reset_o)
		else $error("reset_o did not fall");

	a_mcu_window: assert property (@(posedge clk_32) disable iff (!xsint)
		$past(shadow_cnt) <= st_glue_pkg::MCU_RESET_ASSERT_AT
		&& $past(shadow_cnt) >= st_glue_pkg::MCU_RESET_RELEASE_BELOW |-> !mcu_reset_n_o)
		else $error("mcu_reset_n_o high inside its reset window");

	a_audio_mix: assert property (@(posedge clk_32) disable iff (!xsint)
		$past(xsint, 3) |->
		int'($signed(audio_o.left)) == mix_term(int'($past(audio_i.ym, 3)), 10, 4)
			+ mix_term(int'($past(audio_i.dma_l, 3)), 8, 6)
		&& int'($signed(audio_o.right)) == mix_term(int'($past(audio_i.ym, 3)), 10, 4)
			+ mix_term(int'($past(audio_i.dma_r, 3)), 8, 6))
		else $error("audio_o does not match the mix of the sample three cycles back");

endmodule

bind st_glue_top st_glue_assert st_glue_assert_i (
	.clk_32        (clk_32),
	.xsint         (xsint),
	.sys_reset_n_i (sys_reset_n_i),
	.reset_o       (reset_o),
	.mcu_reset_n_o (mcu_reset_n_o),
	.en_2m_o       (en_2m_o),
	.audio_i       (audio_i),
	.audio_o       (audio_o)
);

`default_nettype wire

//--- dv/tb_st_glue.sv
`timescale 1ns/10ps
`default_nettype none

module tb_st_glue;

	logic                    clk_32 = 1'b0;
	logic                    xsint;
	logic                    sys_reset_n_i;
	logic                    cpu_reset_n_i;
	logic                    ste_i;
	logic                    mono_detect_i;
	logic                    snd_irq_i;
	st_glue_pkg::rtc_bus_t   rtc_bus_i;
	st_glue_pkg::rtc_time_t  rtc_time_i;
	st_glue_pkg::audio_in_t  audio_i;
	logic                    reset_o;
	logic                    peripheral_reset_o;
	logic                    mcu_reset_n_o;
	logic                    mfp_clk_o;
	logic                    en_2m_o;
	logic                    timer_a_o;
	logic                    mfp_io7_o;
	logic [3:0]              rtc_rdata_o;
	st_glue_pkg::audio_out_t audio_o;

	int          errors = 0;
	int unsigned lcg_state = 32'd5181; // fixed seed

	st_glue_top st_glue_top_i (.*);

	always #10 clk_32 = ~clk_32; // 20 ns period

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 8; // low bits of an lcg are poor
	endfunction

	// offset binary sample to its 15 bit term of sign, sample and top bits of sample
	function automatic int mix_term(input int raw, input int bits, input int tail);
		int c;
		c = raw - (1 << (bits - 1)); // centred
		return c * (1 << tail) + ((c & ((1 << bits) - 1)) >> (bits - tail));
	endfunction

	task automatic check_val(input string what, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timeout: %s did not happen in time", what);
	endtask

	// all drives land 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_32);
		#2;
	endtask

	task automatic read_rtc(input int addr, input int exp);
		rtc_bus_i.cs = 1'b1;
		rtc_bus_i.wr = 1'b0;
		rtc_bus_i.addr = 4'(addr);
		#1; // combinational read
		check_val($sformatf("rtc read of address %0d", addr), int'(rtc_rdata_o), exp);
		next_cycle();
	endtask

	task automatic write_rtc(input int addr, input int data);
		rtc_bus_i.cs = 1'b1;
		rtc_bus_i.wr = 1'b1;
		rtc_bus_i.addr = 4'(addr);
		rtc_bus_i.wdata = 4'(data);
		next_cycle(); // taken at this edge
		rtc_bus_i.wr = 1'b0;
	endtask

	task automatic reset_sequence();
		int n;
		int first_low;
		int low_cnt;
		n = 0;
		first_low = 0;
		low_cnt = 0;
		sys_reset_n_i = 1'b0;
		repeat (3) next_cycle();
		sys_reset_n_i = 1'b1;
		do begin
			next_cycle();
			n++;
			if (!mcu_reset_n_o) begin
				low_cnt++;
				if (first_low == 0) begin
					first_low = n;
				end
			end
		end while (reset_o && n < 200);
		if (reset_o) begin
			report_timeout("reset_o release");
		end
		check_val("reset_o release cycle", n, int'(st_glue_pkg::RESET_CYCLES) + 1);
		check_val("mcu_reset_n_o first low cycle", first_low,
			int'(st_glue_pkg::RESET_CYCLES - st_glue_pkg::MCU_RESET_ASSERT_AT) + 1);
		check_val("mcu_reset_n_o low cycles", low_cnt,
			int'(st_glue_pkg::MCU_RESET_ASSERT_AT - st_glue_pkg::MCU_RESET_RELEASE_BELOW) + 1);
		check_val("peripheral_reset_o one cycle behind", int'(peripheral_reset_o), 1);
		next_cycle();
		check_val("peripheral_reset_o", int'(peripheral_reset_o), 0);
		cpu_reset_n_i = 1'b0; // reset instruction
		next_cycle();
		check_val("peripheral_reset_o on cpu reset", int'(peripheral_reset_o), 1);
		check_val("mcu_reset_n_o on cpu reset", int'(mcu_reset_n_o), 0);
		next_cycle();
		check_val("mcu_reset_n_o after cpu reset", int'(mcu_reset_n_o), 1); // count is 0
		cpu_reset_n_i = 1'b1;
		repeat (2) next_cycle();
		check_val("peripheral_reset_o after cpu reset", int'(peripheral_reset_o), 0);
	endtask

	task automatic timebase_rates();
		int     toggles;
		int     gap;
		logic   prev;
		longint err;
		toggles = 0;
		prev = mfp_clk_o;
		repeat (2000) begin
			next_cycle();
			if (mfp_clk_o != prev) begin
				toggles++;
			end
			prev = mfp_clk_o;
		end
		// toggles * sys must sit within one sys of 2000 * 2 * mfp
		err = longint'(toggles) * longint'(st_glue_pkg::SYSTEM_CLOCK_HZ)
			- longint'(4000) * longint'(st_glue_pkg::MFP_CLOCK_HZ);
		if (err < 0) begin
			err = -err;
		end
		if (err > longint'(st_glue_pkg::SYSTEM_CLOCK_HZ)) begin
			errors++;
			$display("** Error at %0t: %0d mfp_clk_o toggles in 2000 cycles", $time, toggles);
		end
		gap = 0;
		while (!en_2m_o && gap < 40) begin
			next_cycle();
			gap++;
		end
		if (!en_2m_o) begin
			report_timeout("first en_2m_o pulse");
		end
		repeat (4) begin
			gap = 0;
			do begin
				next_cycle();
				gap++;
			end while (!en_2m_o && gap < 40);
			check_val("en_2m_o period", gap, int'(st_glue_pkg::EN_2M_DIV));
		end
	endtask

	task automatic sound_irq_delay();
		int n;
		int lo;
		int hi;
		int io7_exp [4];
		lo = (int'(st_glue_pkg::SND_IRQ_DELAY_LEN) - 1) * int'(st_glue_pkg::EN_2M_DIV) + 1;
		hi = int'(st_glue_pkg::SND_IRQ_DELAY_LEN) * int'(st_glue_pkg::EN_2M_DIV);
		io7_exp = '{0, 1, 1, 0}; // with snd_irq_i high io7 is mono_detect_i xor ste_i
		n = 0;
		snd_irq_i = 1'b1;
		do begin
			next_cycle();
			n++;
		end while (!timer_a_o && n < 200);
		if (!timer_a_o) begin
			report_timeout("timer_a_o rise after snd_irq_i");
		end else if (n < lo || n > hi) begin
			errors++;
			$display("** Error at %0t: timer_a_o rose after %0d cycles, expected %0d to %0d",
				$time, n, lo, hi);
		end
		snd_irq_i = 1'b0;
		#1; // asynchronous clear
		check_val("timer_a_o after snd_irq_i fell", int'(timer_a_o), 0);
		for (int i = 0; i < 4; i++) begin
			next_cycle();
			snd_irq_i = 1'b1;
			ste_i = i[0];
			mono_detect_i = i[1];
			#1;
			check_val("mfp_io7_o", int'(mfp_io7_o), io7_exp[i]);
		end
		next_cycle();
		snd_irq_i = 1'b0;
		ste_i = 1'b0;
		mono_detect_i = 1'b0;
	endtask

	task automatic rtc_registers();
		int          bank0 [13];
		int          store [13];
		int unsigned r;
		// 12:37:45, day 3, 25.08, year digits 9 3
		rtc_time_i = {4'd5, 4'd4, 4'd7, 4'd3, 4'd2, 4'd1, 4'd5, 4'd2,
			4'd8, 4'd0, 4'd3, 4'd9, 4'd3};
		bank0 = '{5, 4, 7, 3, 2, 1, 3, 5, 2, 8, 0, 3 + int'(st_glue_pkg::RTC_YEAR_BIAS), 9};
		next_cycle();
		for (int a = 0; a < 13; a++) begin
			read_rtc(a, bank0[a]);
		end
		read_rtc(13, 8);  // bank 0
		read_rtc(14, 0);
		read_rtc(15, 12);
		write_rtc(13, 1); // bank 1
		for (int a = 0; a < 13; a++) begin
			r = lcg_next();
			store[a] = r % 16;
			write_rtc(a, store[a]);
		end
		for (int a = 0; a < 13; a++) begin
			read_rtc(a, store[a]);
		end
		read_rtc(13, 9);
		rtc_time_i = '0; // chip looks absent
		for (int a = 0; a < 16; a++) begin
			read_rtc(a, 15);
		end
		rtc_bus_i = '0;
	endtask

	task automatic audio_pipeline();
		st_glue_pkg::audio_in_t smp [200];
		int unsigned            r;
		for (int i = 0; i < 203; i++) begin
			if (i >= 3) begin // three samples in flight
				check_val("audio_o.left", int'($signed(audio_o.left)),
					mix_term(int'(smp[i-3].ym), 10, 4) + mix_term(int'(smp[i-3].dma_l), 8, 6));
				check_val("audio_o.right", int'($signed(audio_o.right)),
					mix_term(int'(smp[i-3].ym), 10, 4) + mix_term(int'(smp[i-3].dma_r), 8, 6));
			end
			if (i < 200) begin
				r = lcg_next(); // 24 random bits per call
				smp[i].ym = 10'(r >> 14);
				smp[i].dma_l = 8'(r >> 6);
				r = lcg_next();
				smp[i].dma_r = 8'(r >> 16);
				if (i == 0) begin
					smp[i] = '0; // bottom of range
				end else if (i == 1) begin
					smp[i] = '1; // top of range
				end
				audio_i = smp[i];
			end
			next_cycle();
		end
	endtask

	initial begin
		xsint = 1'b0;
		sys_reset_n_i = 1'b0;
		cpu_reset_n_i = 1'b1;
		ste_i = 1'b0;
		mono_detect_i = 1'b0;
		snd_irq_i = 1'b0;
		rtc_bus_i = '0;
		rtc_time_i = '0;
		audio_i = {st_glue_pkg::YM_MIDPOINT, st_glue_pkg::DMA_MIDPOINT, st_glue_pkg::DMA_MIDPOINT};
		repeat (5) @(posedge clk_32);
		#2;
		xsint = 1'b1;
		reset_sequence();
		timebase_rates();
		sound_irq_delay();
		rtc_registers();
		audio_pipeline();
		$display("checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
common/st_glue_pkg.sv
hdl/st_reset_seq.sv
hdl/st_mfp_timebase.sv
rtc/st_rtc.sv
audio/st_audio_mix.sv
hdl/st_glue_top.sv
dv/st_glue_assert.sv
dv/tb_st_glue.sv

//--- Makefile
# Verilator build and run of the ST glue testbench
# override on the command line, e.g. make sim TOP=tb_st_glue

VERILATOR ?= verilator
TOP       ?= tb_st_glue
FLAGS     ?= --binary --timing --assert
BUILD     ?= obj_dir
PASS      := Done: no errors

.PHONY: sim clean

# pass only when the run prints the pass line
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f filelist.f
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(BUILD)
